//--- design/sens_par_pkg.sv
// shared types, register offsets and bit positions of the parallel sensor port, imported where needed
package sens_par_pkg;

    typedef logic [7:0]  cmd_byte_t;       // one byte of command or status stream
    typedef logic [15:0] cmd_addr_t;       // full command address
    typedef logic [2:0]  reg_sel_t;        // register offset inside window
    typedef logic [31:0] cmd_data_t;       // command payload
    typedef logic [15:0] line_width_t;     // regenerated line width
    typedef logic [11:0] pixel_t;          // one pixel sample
    typedef logic [13:0] status_payload_t; // pin and state bits sent upstream

    localparam reg_sel_t SENSIO_CTRL   = 3'd0; // mrst/arst/aro pairs
    localparam reg_sel_t SENSIO_STATUS = 3'd1; // bit 0 request, bit 1 auto mode
    localparam reg_sel_t SENSIO_JTAG   = 3'd2; // external fpga programming pins
    localparam reg_sel_t SENSIO_WIDTH  = 3'd3; // line width, 0 follows hact

    localparam int JTAG_PGMEN = 8; // programming mode enable
    localparam int JTAG_PROG  = 6; // prog_b, driven inverted
    localparam int JTAG_TCK   = 4;
    localparam int JTAG_TMS   = 2;
    localparam int JTAG_TDI   = 0;

    localparam int CTRL_MRST = 0;
    localparam int CTRL_ARST = 2;
    localparam int CTRL_ARO  = 4;

    localparam int CMD_NUM_BYTES = 6; // al, ah, d0..d3

    typedef enum logic [1:0] {
        IDLE,  // nothing pending
        REQ,   // request raised, waiting for start
        BYTE1, // sequence and low payload bits
        BYTE2  // high payload bits
    } status_state_t;

endpackage

//--- design/sens_cmd_deser.sv
// collects the six-byte command stream and issues one write pulse for the sensor register window
`timescale 1ns/1ps

module sens_cmd_deser
    import sens_par_pkg::*;
#(
    parameter cmd_addr_t SENSIO_ADDR      = 16'h0330, // window base
    parameter cmd_addr_t SENSIO_ADDR_MASK = 16'h07f8  // address bits compared
) (
    input  logic      mclk,
    input  logic      rst,
    input  cmd_byte_t cmd_ad_i,   // al, ah, d0..d3 on consecutive cycles
    input  logic      cmd_stb_i,  // high with first byte
    output reg_sel_t  cmd_a_o,    // low address bits
    output cmd_data_t cmd_data_o,
    output logic      cmd_we_o    // cycle after last byte, window hits only
);

    logic [2:0]  byte_cnt;  // 0 idle, else index of byte now on bus
    logic [39:0] sr;        // first five bytes, al ends up lowest
    logic        last_byte;
    cmd_addr_t   addr;

    assign last_byte = byte_cnt == 3'(CMD_NUM_BYTES - 1);
    assign addr      = sr[15:0]; // {ah, al} once five bytes are in

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            byte_cnt <= '0;
            cmd_we_o <= 1'b0;
        end else begin
            if (cmd_stb_i)
                byte_cnt <= 3'd1;
            else if (last_byte)
                byte_cnt <= '0;                 // command complete
            else if (byte_cnt != '0)
                byte_cnt <= byte_cnt + 3'd1;
            cmd_we_o <= last_byte &&
                        ((addr & SENSIO_ADDR_MASK) == (SENSIO_ADDR & SENSIO_ADDR_MASK));
        end
    end

    always_ff @(posedge mclk) begin
        sr <= {cmd_ad_i, sr[39:8]};             // shift in from the top
        if (last_byte) begin
            cmd_data_o <= {cmd_ad_i, sr[39:16]}; // d3 arriving now, d0 least significant
            cmd_a_o    <= sr[2:0];
        end
    end

    // the source never starts a command before the previous one is done
    a_no_overlap: assert property (@(posedge mclk) disable iff (rst)
        cmd_stb_i |-> byte_cnt == '0);

    a_we_pulse: assert property (@(posedge mclk) disable iff (rst)
        cmd_we_o |=> !cmd_we_o);

endmodule

//--- design/sens_ctrl_regs.sv
// decodes register writes into control and jtag pin levels, line width and status requests
`timescale 1ns/1ps

module sens_ctrl_regs
    import sens_par_pkg::*;
(
    input  logic        mclk,
    input  logic        rst,
    input  reg_sel_t    cmd_a_i,
    input  cmd_data_t   cmd_data_i,
    input  logic        cmd_we_i,
    output logic        pgmen_o,          // external fpga programming mode
    output logic        prog_o,
    output logic        tck_o,
    output logic        tms_o,
    output logic        tdi_o,
    output logic        imrst_o,          // sensor master reset level
    output logic        iarst_o,
    output logic        iaro_soft_o,      // aro when not triggered
    output line_width_t width_m1_o,       // width minus one
    output logic        width_internal_o, // regenerate hact from width
    output logic        status_req_o,     // one cycle status request
    output logic        status_auto_o     // send status on every change
);

    cmd_data_t data_r;       // write data, aligned with decoded strobes
    logic      set_ctrl_r;
    logic      set_status_r;
    logic      set_jtag_r;
    logic      set_width_r;

    // pair 3 sets, 2 clears, 0/1 holds
    function automatic logic pair_upd(input logic cur, input logic [1:0] pair);
        return pair[1] ? pair[0] : cur;
    endfunction

    assign status_req_o = set_status_r && data_r[0];

    always_ff @(posedge mclk) begin
        if (cmd_we_i)
            data_r <= cmd_data_i;
    end

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            set_ctrl_r       <= 1'b0;
            set_status_r     <= 1'b0;
            set_jtag_r       <= 1'b0;
            set_width_r      <= 1'b0;
            pgmen_o          <= 1'b0;
            prog_o           <= 1'b0;
            tck_o            <= 1'b0;
            tms_o            <= 1'b0;
            tdi_o            <= 1'b0;
            imrst_o          <= 1'b0;
            iarst_o          <= 1'b0;
            iaro_soft_o      <= 1'b0;
            width_m1_o       <= '0;
            width_internal_o <= 1'b0;
            status_auto_o    <= 1'b0;
        end else begin
            set_ctrl_r   <= cmd_we_i && (cmd_a_i == SENSIO_CTRL);  // other offsets dropped
            set_status_r <= cmd_we_i && (cmd_a_i == SENSIO_STATUS);
            set_jtag_r   <= cmd_we_i && (cmd_a_i == SENSIO_JTAG);
            set_width_r  <= cmd_we_i && (cmd_a_i == SENSIO_WIDTH);
            if (set_jtag_r) begin
                pgmen_o <= pair_upd(pgmen_o, data_r[JTAG_PGMEN +: 2]);
                prog_o  <= pair_upd(prog_o,  data_r[JTAG_PROG  +: 2]);
                tck_o   <= pair_upd(tck_o,   data_r[JTAG_TCK   +: 2]);
                tms_o   <= pair_upd(tms_o,   data_r[JTAG_TMS   +: 2]);
                tdi_o   <= pair_upd(tdi_o,   data_r[JTAG_TDI   +: 2]);
            end
            if (set_ctrl_r) begin
                imrst_o     <= pair_upd(imrst_o,     data_r[CTRL_MRST +: 2]);
                iarst_o     <= pair_upd(iarst_o,     data_r[CTRL_ARST +: 2]);
                iaro_soft_o <= pair_upd(iaro_soft_o, data_r[CTRL_ARO  +: 2]); // own enable
            end
            if (set_width_r) begin
                width_m1_o       <= line_width_t'(data_r) - 1'b1;
                width_internal_o <= |line_width_t'(data_r); // 0 keeps received hact
            end
            if (set_status_r)
                status_auto_o <= data_r[1];
        end
    end

    a_one_strobe: assert property (@(posedge mclk) disable iff (rst)
        $onehot0({set_ctrl_r, set_status_r, set_jtag_r, set_width_r}));

endmodule

//--- design/sens_hact_regen.sv
// passes on the received line-valid signal or regenerates it from the programmed line width
`timescale 1ns/1ps

module sens_hact_regen
    import sens_par_pkg::*;
(
    input  logic        mclk,
    input  logic        rst,
    input  logic        hact_s_i,         // hact, already sampled once
    input  line_width_t width_m1_i,
    input  logic        width_internal_i, // 1 counts width, 0 follows input
    output logic        hact_o
);

    logic        hact_d;   // delayed copy for rise detect
    logic        start;
    line_width_t cnt;      // cycles left after current one

    assign start = hact_s_i && !hact_d && !hact_o; // rises inside a line ignored

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            hact_d <= 1'b0;
            hact_o <= 1'b0;
            cnt    <= '0;
        end else begin
            hact_d <= hact_s_i;
            if (start)
                hact_o <= 1'b1;
            else if (width_internal_i ? (cnt == '0) : !hact_s_i)
                hact_o <= 1'b0;
            if (start)
                cnt <= width_m1_i;
            else if (hact_o && width_internal_i)
                cnt <= cnt - 1'b1;
        end
    end

    // while counting, the line ends before the counter runs past zero
    a_no_wrap: assert property (@(posedge mclk) disable iff (rst)
        hact_o && $past(hact_o) && $past(width_internal_i) |-> cnt < $past(cnt));

endmodule

//--- design/sens_pgm_pins.sv
// drives sensor control pins for normal sensor use or external fpga programming, probes the program pin
`timescale 1ns/1ps

module sens_pgm_pins (
    input  logic mclk,
    input  logic rst,
    input  logic trigger_mode_i, // aro follows trigger
    input  logic trig_i,
    input  logic pgmen_i,
    input  logic prog_i,
    input  logic tck_i,
    input  logic tms_i,
    input  logic tdi_i,
    input  logic imrst_i,
    input  logic iarst_i,
    input  logic iaro_soft_i,
    input  logic senspgm_s_i,    // sampled program pin
    output logic aro_o,          // aro or tck
    output logic arst_o,         // arst or tms
    output logic mrst_o,
    output logic mrst_oe_o,      // off while reading done
    output logic senspgm_o,
    output logic senspgm_oe_o,
    output logic pxd0_o,         // tdi to external fpga
    output logic pxd0_oe_o,
    output logic iaro_o,
    output logic force_o         // program pin level probed after programming
);

    logic pgmen_d;

    assign iaro_o       = trigger_mode_i ? ~trig_i : iaro_soft_i; // trigger active low
    assign aro_o        = pgmen_i ? tck_i : iaro_o;
    assign arst_o       = pgmen_i ? tms_i : iarst_i;
    assign mrst_o       = imrst_i;
    assign mrst_oe_o    = ~pgmen_i;                 // mrst reads done when programming
    assign senspgm_o    = pgmen_i ? ~prog_i : force_o;
    assign senspgm_oe_o = pgmen_i | force_o;
    assign pxd0_o       = tdi_i;
    assign pxd0_oe_o    = pgmen_i;

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            pgmen_d <= 1'b0;
            force_o <= 1'b0;
        end else begin
            pgmen_d <= pgmen_i;
            if (pgmen_d && !pgmen_i)
                force_o <= senspgm_s_i; // keep level the board left on the pin
        end
    end

endmodule

//--- design/sens_status_gen.sv
// collects pin and state bits and sends them upstream as three-byte status packets
`timescale 1ns/1ps

module sens_status_gen
    import sens_par_pkg::*;
#(
    parameter cmd_byte_t STATUS_REG_ADDR = 8'h31 // first byte of every packet
) (
    input  logic            mclk,
    input  logic            rst,
    input  logic            status_req_i,   // one cycle request
    input  logic            status_auto_i,  // send on every payload change
    input  status_payload_t payload_i,
    output cmd_byte_t       status_ad_o,    // addr, {seq, p[5:0]}, p[13:6]
    output logic            status_rq_o,
    input  logic            status_start_i  // grant, address byte goes now
);

    status_state_t   state;
    status_payload_t last_sent;  // payload of previous packet
    logic [1:0]      seq;        // wraps at 4
    cmd_byte_t       ad_r;
    cmd_byte_t       hi_byte;    // held for third byte
    logic            req_pend;   // request seen while sending
    logic            grant;

    assign grant       = (state == REQ) && status_start_i;
    assign status_rq_o = state == REQ;
    assign status_ad_o = grant ? STATUS_REG_ADDR : ad_r;

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            state     <= IDLE;
            last_sent <= '0;
            seq       <= '0;
            ad_r      <= '0;
            req_pend  <= 1'b0;
        end else begin
            if (state == IDLE)
                req_pend <= 1'b0;
            else if (status_req_i && state != REQ)
                req_pend <= 1'b1;             // served once back in idle
            case (state)
                IDLE: begin
                    if (status_req_i || req_pend || (status_auto_i && payload_i != last_sent))
                        state <= REQ;
                end
                REQ: begin
                    if (status_start_i) begin
                        last_sent <= payload_i;
                        ad_r      <= {seq, payload_i[5:0]};
                        state     <= BYTE1;
                    end
                end
                BYTE1: begin
                    ad_r  <= hi_byte;
                    state <= BYTE2;
                end
                default: begin
                    ad_r  <= '0;               // bus idle between packets
                    seq   <= seq + 2'd1;
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge mclk) begin
        if (grant)
            hi_byte <= payload_i[13:6];
    end

    // request held until upstream grants it
    a_rq_hold: assert property (@(posedge mclk) disable iff (rst)
        status_rq_o && !status_start_i |=> status_rq_o);

endmodule

//--- design/sens_parallel12.sv
// top level of the 12-bit parallel sensor port control core, samples the pixel bus and wires the blocks
`timescale 1ns/1ps

module sens_parallel12
    import sens_par_pkg::*;
#(
    parameter cmd_addr_t SENSIO_ADDR      = 16'h0330,
    parameter cmd_addr_t SENSIO_ADDR_MASK = 16'h07f8,
    parameter cmd_byte_t STATUS_REG_ADDR  = 8'h31
) (
    input  logic      mclk,
    input  logic      rst,
    input  cmd_byte_t cmd_ad_i,
    input  logic      cmd_stb_i,
    output cmd_byte_t status_ad_o,
    output logic      status_rq_o,
    input  logic      status_start_i,
    input  logic      trigger_mode_i,
    input  logic      trig_i,
    input  pixel_t    pxd_i,         // bit 1 is tdo while programming
    input  logic      vact_i,
    input  logic      hact_i,
    input  logic      mrst_i,        // done from external fpga
    input  logic      senspgm_i,
    output pixel_t    pxd_o,
    output logic      vact_o,
    output logic      hact_o,
    output logic      aro_o,
    output logic      arst_o,
    output logic      mrst_o,
    output logic      mrst_oe_o,
    output logic      senspgm_o,
    output logic      senspgm_oe_o,
    output logic      pxd0_o,
    output logic      pxd0_oe_o
);

    pixel_t          pxd_r;        // pin inputs, sampled once
    logic            vact_r;
    logic            hact_r;
    logic            mrst_r;
    logic            senspgm_r;
    reg_sel_t        cmd_a;
    cmd_data_t       cmd_data;
    logic            cmd_we;
    logic            pgmen, prog, tck, tms, tdi;
    logic            imrst, iarst, iaro_soft, iaro, force_pgm;
    line_width_t     width_m1;
    logic            width_internal;
    logic            status_req, status_auto;
    status_payload_t payload;

    assign pxd_o  = pxd_r;
    assign vact_o = vact_r;
    assign payload = {vact_r, hact_o, iaro, iarst, imrst, tdi, tms, tck, prog, pgmen,
                      force_pgm, senspgm_r, pxd_r[1], mrst_r}; // done in bit 0

    always_ff @(posedge mclk) begin
        pxd_r     <= pxd_i;
        vact_r    <= vact_i;
        hact_r    <= hact_i;
        mrst_r    <= mrst_i;
        senspgm_r <= senspgm_i;
    end

    sens_cmd_deser #(
        .SENSIO_ADDR      (SENSIO_ADDR),
        .SENSIO_ADDR_MASK (SENSIO_ADDR_MASK)
    ) sens_cmd_deser_i (
        .mclk (mclk), .rst (rst), .cmd_ad_i (cmd_ad_i), .cmd_stb_i (cmd_stb_i),
        .cmd_a_o (cmd_a), .cmd_data_o (cmd_data), .cmd_we_o (cmd_we)
    );

    sens_ctrl_regs sens_ctrl_regs_i (
        .mclk (mclk), .rst (rst), .cmd_a_i (cmd_a), .cmd_data_i (cmd_data), .cmd_we_i (cmd_we),
        .pgmen_o (pgmen), .prog_o (prog), .tck_o (tck), .tms_o (tms), .tdi_o (tdi),
        .imrst_o (imrst), .iarst_o (iarst), .iaro_soft_o (iaro_soft),
        .width_m1_o (width_m1), .width_internal_o (width_internal),
        .status_req_o (status_req), .status_auto_o (status_auto)
    );

    sens_hact_regen sens_hact_regen_i (
        .mclk (mclk), .rst (rst), .hact_s_i (hact_r), .width_m1_i (width_m1),
        .width_internal_i (width_internal), .hact_o (hact_o)
    );

    sens_pgm_pins sens_pgm_pins_i (
        .mclk (mclk), .rst (rst), .trigger_mode_i (trigger_mode_i), .trig_i (trig_i),
        .pgmen_i (pgmen), .prog_i (prog), .tck_i (tck), .tms_i (tms), .tdi_i (tdi),
        .imrst_i (imrst), .iarst_i (iarst), .iaro_soft_i (iaro_soft),
        .senspgm_s_i (senspgm_r),
        .aro_o (aro_o), .arst_o (arst_o), .mrst_o (mrst_o), .mrst_oe_o (mrst_oe_o),
        .senspgm_o (senspgm_o), .senspgm_oe_o (senspgm_oe_o),
        .pxd0_o (pxd0_o), .pxd0_oe_o (pxd0_oe_o), .iaro_o (iaro), .force_o (force_pgm)
    );

    sens_status_gen #(
        .STATUS_REG_ADDR (STATUS_REG_ADDR)
    ) sens_status_gen_i (
        .mclk (mclk), .rst (rst), .status_req_i (status_req), .status_auto_i (status_auto),
        .payload_i (payload), .status_ad_o (status_ad_o), .status_rq_o (status_rq_o),
        .status_start_i (status_start_i)
    );

endmodule

//--- verif/sens_tb_clk.sv
// testbench clock and reset source, free-running mclk with reset held over the first cycles
`timescale 1ns/1ps

module sens_tb_clk #(
    parameter real PERIOD_NS  = 4.0, // mclk period
    parameter int  RST_CYCLES = 4    // cycles with reset high
) (
    output logic mclk_o,
    output logic rst_o
);

    initial begin
        mclk_o = 1'b0;
        forever #(PERIOD_NS / 2.0) mclk_o = ~mclk_o;
    end

    initial begin
        rst_o = 1'b1;
        repeat (RST_CYCLES) @(posedge mclk_o);
        rst_o <= 1'b0; // released on an edge, like any other input
    end

endmodule

//--- verif/sens_parallel12_tb.sv
// testbench for the parallel sensor port core, random writes and pin traffic checked against a model
`timescale 1ns/1ps

module sens_parallel12_tb
    import sens_par_pkg::*;
();

    localparam cmd_addr_t WIN_BASE    = 16'h0330;
    localparam cmd_addr_t WIN_MASK    = 16'h07f8;
    localparam cmd_byte_t STATUS_ADDR = 8'h31;
    localparam int N_WIN = 24, N_PIN = 16, N_WIDTH = 6, N_FOLLOW = 4, N_PIX = 32, N_AUTO = 6;
    localparam int RQ_WAIT     = 40;                          // cycles allowed for status_rq_o
    localparam int N_CMD       = N_WIN + N_PIN + N_WIDTH + 3;
    localparam int N_PULSE     = 2 * N_WIDTH + N_FOLLOW;
    localparam int N_PKT       = 1 + N_AUTO;
    localparam int CYCLE_LIMIT = 12 * N_CMD + 72 * N_PULSE + (RQ_WAIT + 16) * N_PKT + N_PIX + 100;

    logic      mclk, rst;
    cmd_byte_t cmd_ad_i, status_ad_o;
    logic      cmd_stb_i, status_rq_o, status_start_i;
    logic      trigger_mode_i, trig_i, vact_i, hact_i, mrst_i, senspgm_i;
    pixel_t    pxd_i, pxd_o;
    logic      vact_o, hact_o, aro_o, arst_o, mrst_o, mrst_oe_o;
    logic      senspgm_o, senspgm_oe_o, pxd0_o, pxd0_oe_o;

    logic [15:0] lfsr = 16'd45546;
    int          cycles = 0;
    string       cur_test;
    int          test_checks = 0, test_errors = 0, all_checks = 0, all_errors = 0, n_tests = 0;
    logic        m_pgmen, m_prog, m_tck, m_tms, m_tdi;      // model of register levels
    logic        m_imrst, m_iarst, m_iaro, m_force;
    logic [1:0]  m_seq;                                      // next packet sequence

    sens_tb_clk clk_gen_i (.mclk_o(mclk), .rst_o(rst));

    sens_parallel12 #(
        .SENSIO_ADDR      (WIN_BASE),
        .SENSIO_ADDR_MASK (WIN_MASK),
        .STATUS_REG_ADDR  (STATUS_ADDR)
    ) sens_parallel12_i (.*);

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? (s >> 1) ^ 16'hb400 : s >> 1; // galois form, x^16+x^14+x^13+x^11+1
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[30:0], lfsr[0]};                 // one step per bit
            lfsr = lfsr_next(lfsr);
        end
        return r;
    endfunction

    function automatic logic pair_rule(input logic cur, input logic [1:0] pair);
        case (pair)
            2'b11:   return 1'b1;
            2'b10:   return 1'b0;
            default: return cur;                      // 0 and 1 hold
        endcase
    endfunction

    function automatic logic iaro_model();
        return trigger_mode_i ? !trig_i : m_iaro;     // trigger input active low
    endfunction

    function automatic status_payload_t payload_model();
        return {vact_i, 1'b0, iaro_model(), m_iarst, m_imrst, m_tdi, m_tms, m_tck, m_prog,
                m_pgmen, m_force, senspgm_i, pxd_i[1], mrst_i}; // hact idle in status tests
    endfunction

    task automatic start_test(input string name);
        cur_test    = name;
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic end_test();
        $display("test %s: %0d checks, %0d errors", cur_test, test_checks, test_errors);
        all_checks += test_checks;
        all_errors += test_errors;
        n_tests++;
    endtask

    task automatic compare(input string what, input logic [31:0] exp, input logic [31:0] act);
        test_checks++;
        if (exp !== act) begin
            test_errors++;
            $display("error %s %s: expected %0h actual %0h", cur_test, what, exp, act);
        end
    endtask

    task automatic check_pins();
        compare("aro", m_pgmen ? m_tck : iaro_model(), aro_o);
        compare("arst", m_pgmen ? m_tms : m_iarst, arst_o);
        compare("mrst", m_imrst, mrst_o);
        compare("mrst_oe", !m_pgmen, mrst_oe_o);
        compare("senspgm", m_pgmen ? !m_prog : m_force, senspgm_o);
        compare("senspgm_oe", m_pgmen | m_force, senspgm_oe_o);
        compare("pxd0", m_tdi, pxd0_o);
        compare("pxd0_oe", m_pgmen, pxd0_oe_o);
    endtask

    // al, ah, d0..d3 on six consecutive cycles, returns on the edge that takes d3
    task automatic send_cmd(input cmd_addr_t addr, input cmd_data_t data);
        logic [47:0] bytes;
        bytes = {data, addr};
        for (int i = 0; i < CMD_NUM_BYTES; i++) begin
            @(posedge mclk);
            cmd_stb_i <= (i == 0);
            cmd_ad_i  <= bytes[8*i +: 8];
        end
        @(posedge mclk);
        cmd_ad_i <= '0;
    endtask

    task automatic reg_write(input cmd_addr_t addr, input cmd_data_t data);
        logic hit;
        logic pgmen_was;
        hit       = (addr & WIN_MASK) == (WIN_BASE & WIN_MASK);
        pgmen_was = m_pgmen;
        send_cmd(addr, data);
        repeat (2) @(posedge mclk);                   // write pulse, then levels
        if (hit && addr[2:0] == SENSIO_JTAG) begin
            m_pgmen = pair_rule(m_pgmen, data[JTAG_PGMEN +: 2]);
            m_prog  = pair_rule(m_prog, data[JTAG_PROG +: 2]);
            m_tck   = pair_rule(m_tck, data[JTAG_TCK +: 2]);
            m_tms   = pair_rule(m_tms, data[JTAG_TMS +: 2]);
            m_tdi   = pair_rule(m_tdi, data[JTAG_TDI +: 2]);
        end
        if (hit && addr[2:0] == SENSIO_CTRL) begin
            m_imrst = pair_rule(m_imrst, data[CTRL_MRST +: 2]);
            m_iarst = pair_rule(m_iarst, data[CTRL_ARST +: 2]);
            m_iaro  = pair_rule(m_iaro, data[CTRL_ARO +: 2]);
        end
        @(negedge mclk);
        check_pins();
        if (pgmen_was && !m_pgmen) begin
            m_force = senspgm_i;                      // pin level left by the board
            @(negedge mclk);
            check_pins();
        end
    endtask

    // hact_i high for len cycles, hact_o expected high for exp_len cycles two edges later
    // rerise adds a one-cycle second pulse that starts inside the regenerated line
    task automatic hact_pulse(input int len, input int exp_len, input logic rerise);
        for (int i = 0; i < len + exp_len + 4; i++) begin
            @(posedge mclk);
            hact_i <= (i < len) || (rerise && i == len + 1);
            @(negedge mclk);
            compare("hact", (i >= 2 && i < exp_len + 2), hact_o);
        end
    endtask

    task automatic get_packet();
        status_payload_t p;
        int              wait_n;
        wait_n = 0;
        while (!status_rq_o && wait_n < RQ_WAIT) begin
            @(negedge mclk);
            wait_n++;
        end
        if (!status_rq_o) begin
            $display("status request never came in test %s", cur_test);
            test_errors++;
        end
        repeat (rand_bits(3)) @(posedge mclk);       // upstream grant latency
        p = payload_model();
        @(posedge mclk);
        status_start_i <= 1'b1;
        @(negedge mclk);
        compare("address byte", STATUS_ADDR, status_ad_o);
        @(posedge mclk);
        status_start_i <= 1'b0;
        @(negedge mclk);
        compare("rq after start", 0, status_rq_o);
        compare("sequence byte", {m_seq, p[5:0]}, status_ad_o);
        @(negedge mclk);
        compare("high byte", p[13:6], status_ad_o);
        @(negedge mclk);
        compare("bus idle", 0, status_ad_o);
        m_seq = m_seq + 2'd1;                         // wraps at 4
    endtask

    always @(posedge mclk) begin
        cycles <= cycles + 1;
        if (cycles == CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, the tests did not finish", cycles);
            $display("=== FAIL ===");
            $finish;
        end
    end

    initial begin
        cmd_addr_t a;
        cmd_data_t d;
        int        len;
        int        w;
        pixel_t    prev_pxd;
        logic      prev_vact;
        cmd_ad_i       = '0;
        cmd_stb_i      = 1'b0;
        status_start_i = 1'b0;
        trigger_mode_i = 1'b0;
        trig_i         = 1'b0;
        pxd_i          = '0;
        vact_i         = 1'b0;
        hact_i         = 1'b0;
        mrst_i         = 1'b0;
        senspgm_i      = 1'b0;
        {m_pgmen, m_prog, m_tck, m_tms, m_tdi, m_imrst, m_iarst, m_iaro, m_force} = '0;
        m_seq = '0;
        @(negedge rst);

        start_test("cmd_window");
        repeat (N_WIN) begin
            a = 16'(rand_bits(16));
            if (rand_bits(1) == 1)
                a = (a & ~WIN_MASK) | (WIN_BASE & WIN_MASK);
            else if ((a & WIN_MASK) == (WIN_BASE & WIN_MASK))
                a = a ^ 16'h0100;                     // random hit moved out of the window
            a[2:0] = 3'(rand_bits(1) << 1);           // ctrl or jtag offset
            reg_write(a, rand_bits(32));
        end
        end_test();

        start_test("pin_mux");
        repeat (N_PIN) begin
            @(posedge mclk);
            trigger_mode_i <= 1'(rand_bits(1));
            trig_i         <= 1'(rand_bits(1));
            senspgm_i      <= 1'(rand_bits(1));
            d    = rand_bits(32);
            d[9] = 1'b1;                              // pgmen pair sets or clears
            reg_write(WIN_BASE | 16'(SENSIO_JTAG), d);
        end
        end_test();

        start_test("hact_regen");
        repeat (N_WIDTH) begin
            w = 1 + int'(rand_bits(5));
            reg_write(WIN_BASE | 16'(SENSIO_WIDTH), {16'(rand_bits(16)), 16'(w)});
            repeat (2) begin
                len = 1 + int'(rand_bits(5));
                hact_pulse(len, w, len < w);          // second rise only if it lands in the line
            end
        end
        reg_write(WIN_BASE | 16'(SENSIO_WIDTH), {16'(rand_bits(16)), 16'h0000}); // follow mode
        repeat (N_FOLLOW) begin
            len = 1 + int'(rand_bits(5));
            hact_pulse(len, len, 1'b0);
        end
        end_test();

        start_test("pixel_path");
        prev_pxd  = pxd_i;
        prev_vact = vact_i;
        repeat (N_PIX) begin
            @(posedge mclk);
            pxd_i  <= 12'(rand_bits(12));
            vact_i <= 1'(rand_bits(1));
            @(negedge mclk);
            compare("pxd", prev_pxd, pxd_o);
            compare("vact", prev_vact, vact_o);
            prev_pxd  = pxd_i;
            prev_vact = vact_i;
        end
        end_test();

        start_test("status_single");
        reg_write(WIN_BASE | 16'(SENSIO_STATUS), 32'h1); // request, auto off
        get_packet();
        end_test();

        start_test("status_auto");
        reg_write(WIN_BASE | 16'(SENSIO_STATUS), 32'h2); // auto on, no request
        repeat (N_AUTO) begin
            @(posedge mclk);
            if (rand_bits(1) == 1)
                mrst_i <= !mrst_i;
            else
                vact_i <= !vact_i;
            get_packet();
        end
        end_test();

        $display("%0d tests, %0d checks, %0d errors", n_tests, all_checks, all_errors);
        if (all_errors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

//--- sens_parallel12.f
design/sens_par_pkg.sv
design/sens_cmd_deser.sv
design/sens_ctrl_regs.sv
design/sens_hact_regen.sv
design/sens_pgm_pins.sv
design/sens_status_gen.sv
design/sens_parallel12.sv
verif/sens_tb_clk.sv
verif/sens_parallel12_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the testbench with verilator, run it, then judge the run from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module sens_parallel12_tb \
    -f sens_parallel12.f -o sim_tb \
    && ./obj_dir/sim_tb 2>&1 | tee sim.log \
    || { echo "build or run failed"; exit 1; }
grep -q "=== FAIL ===" sim.log && { echo "simulation failed"; exit 1; }
grep -q "=== PASS ===" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"
